// File: edp.f
hw/edpPkg.sv
hw/edpArRegs.sv
hw/edpMq.sv
hw/edpAdder.sv
hw/edpFastMem.sv
hw/edpDiagPort.sv
hw/edp.sv
test/edpTb.sv

// File: Bender.yml
package:
  name: edp

sources:
  - hw/edpPkg.sv
  - hw/edpArRegs.sv
  - hw/edpMq.sv
  - hw/edpAdder.sv
  - hw/edpFastMem.sv
  - hw/edpDiagPort.sv
  - hw/edp.sv
  - target: test
    files:
      - test/edpTb.sv

// File: test/edpTb.sv
`timescale 1ns/1ps

module edpTb;
  import edpPkg::*;

  localparam int fmDepthLog2 = 7;
  // Upper bound on issued operations, sizes the watchdog
  localparam int numVectors = 228;

  typedef struct packed {
    adWordT ad;
    wordT   adx;
    logic   carry;
    logic   ovf;
  } adResT;

  logic                   eboxClk;
  logic                   rstN;
  cramT                   cram;
  logic [fmDepthLog2-1:0] fmAdr;
  wordT                   cacheData;
  wordT                   shiftData;
  wordT                   vmaPc;
  logic                   wbCyc;
  logic                   wbStb;
  logic                   wbWe;
  diagSelT                wbAdr;
  wordT                   wbDatO;
  logic                   wbAck;
  adWordT                 ad;
  wordT                   adx;
  logic                   adCarryOut;
  logic                   adOverflow;

  // Shadow copies of the data path state
  wordT                   shAr;
  wordT                   shArx;
  wordT                   shBr;
  wordT                   shBrx;
  wordT                   shMq;
  wordT                   shFm [2**fmDepthLog2];
  logic [fmDepthLog2-1:0] curAdr;
  // Read data the port should still hold after a write
  wordT                   lastRead;

  cramT        idleWord;
  logic [31:0] lfsrState;
  int          errors;
  int          checks;

  edp #(
    .fmDepthLog2(fmDepthLog2)
  ) DUT (
    .eboxClk, .rstN, .cram, .fmAdr, .cacheData, .shiftData, .vmaPc,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatO, .wbAck,
    .ad, .adx, .adCarryOut, .adOverflow
  );

  initial begin
    eboxClk = 1'b0;
    forever #4 eboxClk = ~eboxClk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic wordT randWord();
    logic [63:0] v;
    v = randBits(36);
    return v[35:0];
  endfunction

  // Expected AD and ADX for a function and its operands
  function automatic adResT refAd(input adFuncT f, input logic [37:0] a, input logic [37:0] b,
                                  input wordT xa, input wordT xb, input logic cin);
    adResT       r;
    logic [38:0] s;
    wordT        sx;
    case (f)
      adAdd: begin
        s = {1'b0, a} + {1'b0, b} + {38'd0, cin};
        sx = xa + xb + {35'd0, cin};
      end
      adSub: begin
        // Carry out means no borrow
        s[37:0] = a - b - {37'd0, !cin};
        s[38] = (a > b) || (a == b && cin);
        sx = xa - xb - {35'd0, !cin};
      end
      adAnd: begin
        s = {1'b0, a & b};
        sx = xa & xb;
      end
      adOr: begin
        s = {1'b0, a | b};
        sx = xa | xb;
      end
      adXor: begin
        s = {1'b0, a ^ b};
        sx = xa ^ xb;
      end
      adPassA: begin
        s = {1'b0, a};
        sx = xa;
      end
      adPassB: begin
        s = {1'b0, b};
        sx = xb;
      end
      default: begin
        s = {1'b0, {38{1'b1}}};
        sx = '1;
      end
    endcase
    r.ad = s[37:0];
    r.adx = sx;
    r.carry = s[38];
    // s[36] is AD bit -1, s[35] is AD bit 0
    r.ovf = (f == adAdd || f == adSub) ? (s[36] ^ s[35]) : 1'b0;
    return r;
  endfunction

  // Operand selection from the shadow registers
  function automatic adResT modelAd(input cramT c);
    wordT        aw;
    logic [37:0] b;
    wordT        xa;
    wordT        xb;
    wordT        f;
    f = shFm[curAdr];
    if (c.adaEn) begin
      aw = '0;
    end else begin
      case (c.ada)
        adaAr:   aw = shAr;
        adaArx:  aw = shArx;
        adaMq:   aw = shMq;
        default: aw = vmaPc;
      endcase
    end
    xa = c.adaEn ? '0 : shArx;
    case (c.adb)
      adbFm: begin
        b = {{2{f[0]}}, f};
        xb = '0;
      end
      adbBrShl: begin
        b = {{2{shBr[0]}}, shBr[1:35], shBrx[0]};
        xb = {shBrx[1:35], 1'b0};
      end
      adbBr: begin
        b = {{2{shBr[0]}}, shBr};
        xb = shBrx;
      end
      default: begin
        b = {shAr, shArx[0:1]};
        xb = {shArx[2:35], 2'b00};
      end
    endcase
    return refAd(c.adFunc, {{2{aw[0]}}, aw}, b, xa, xb, c.carryIn);
  endfunction

  function automatic wordT arSrc(input arSelT sel, input adWordT a, input wordT x,
                                 input wordT cache, input wordT shift);
    case (sel)
      arZero:  return '0;
      arCache: return cache;
      arAd:    return a[0:35];
      arMq:    return shMq;
      arShift: return shift;
      arAdShl: return {a[1:35], x[0]};
      arAdx:   return x;
      default: return a[-2:33];
    endcase
  endfunction

  // ARX shifts as the low half of the AD/ADX double word
  function automatic wordT arxSrc(input arSelT sel, input adWordT a, input wordT x,
                                  input wordT cache, input wordT shift);
    case (sel)
      arAdShl:  return {x[1:35], shMq[0]};
      arAdShr2: return {a[34:35], x[0:33]};
      default:  return arSrc(sel, a, x, cache, shift);
    endcase
  endfunction

  function automatic wordT refMq(input cramT c, input adWordT a, input wordT x,
                                 input wordT shift, input logic carry);
    wordT m;
    if (!c.mqmEn) begin
      m = '0;
    end else begin
      case (c.mqmSel)
        mqmMqShr: m = {x[34:35], shMq[0:33]};
        mqmShift: m = shift;
        mqmAd:    m = a[0:35];
        default:  m = '1;
      endcase
    end
    case (c.mqSel)
      mqLoad:  return m;
      mqShl:   return {m[1:35], carry};
      mqShr:   return {m[1], m[0:34]};
      default: return shMq;
    endcase
  endfunction

  function automatic wordT diagExpect(input diagSelT sel);
    adResT  r;
    adWordT a;
    r = modelAd(idleWord);
    a = r.ad;
    case (sel)
      diagAr:  return shAr;
      diagBr:  return shBr;
      diagMq:  return shMq;
      diagFm:  return shFm[curAdr];
      diagBrx: return shBrx;
      diagArx: return shArx;
      diagAdx: return r.adx;
      default: return a[0:35];
    endcase
  endfunction

  task automatic compareValue(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One microword for one edge, then back to idle
  task automatic applyMicroword(input cramT c, input wordT cache, input wordT shift,
                                input logic [fmDepthLog2-1:0] adr);
    adResT  r;
    adWordT a;
    wordT   src;
    wordT   arNext;
    wordT   arxNext;
    wordT   mqNext;
    @(posedge eboxClk);
    cram <= c;
    cacheData <= cache;
    shiftData <= shift;
    fmAdr <= adr;
    curAdr = adr;
    r = modelAd(c);
    a = r.ad;
    arNext = shAr;
    if (c.arlLoad) begin
      src = arSrc(c.arlSel, a, r.adx, cache, shift);
      arNext[0:17] = src[0:17];
    end
    if (c.arrLoad) begin
      src = arSrc(c.arrSel, a, r.adx, cache, shift);
      arNext[18:35] = src[18:35];
    end
    arxNext = c.arxLoad ? arxSrc(c.arxSel, a, r.adx, cache, shift) : shArx;
    mqNext = refMq(c, a, r.adx, shift, r.carry);
    if (c.brLoad) shBr = shAr;
    if (c.brxLoad) shBrx = shArx;
    if (c.fmWriteL) shFm[adr][0:17] = shAr[0:17];
    if (c.fmWriteR) shFm[adr][18:35] = shAr[18:35];
    shAr = arNext;
    shArx = arxNext;
    shMq = mqNext;
    @(posedge eboxClk);
    cram <= idleWord;
  endtask

  task automatic loadArArx(input wordT arVal, input wordT arxVal, input logic copyB);
    cramT c;
    c = idleWord;
    c.arlSel = arCache;
    c.arrSel = arCache;
    c.arlLoad = 1'b1;
    c.arrLoad = 1'b1;
    c.arxSel = arShift;
    c.arxLoad = 1'b1;
    c.brLoad = copyB;
    c.brxLoad = copyB;
    applyMicroword(c, arVal, arxVal, curAdr);
  endtask

  // Combinational adder outputs, sampled mid-cycle
  task automatic evalAd(input cramT c, input string name);
    adResT r;
    r = modelAd(c);
    @(posedge eboxClk);
    cram <= c;
    @(negedge eboxClk);
    compareValue({name, " ad"}, r.ad, ad);
    compareValue({name, " adx"}, r.adx, adx);
    compareValue({name, " carry"}, r.carry, adCarryOut);
    compareValue({name, " overflow"}, r.ovf, adOverflow);
    @(posedge eboxClk);
    cram <= idleWord;
  endtask

  // Wishbone classic access, ack due exactly one cycle after the request
  task automatic diagAccess(input diagSelT sel, input logic we, input string name);
    wordT exp;
    exp = diagExpect(sel);
    @(posedge eboxClk);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= we;
    wbAdr <= sel;
    @(negedge eboxClk);
    checks++;
    if (wbAck !== 1'b0) begin
      errors++;
      $display("%s: wbAck came before the request was sampled", name);
    end
    @(negedge eboxClk);
    if (wbAck !== 1'b1) begin
      errors++;
      $display("%s: no wbAck one cycle after the request", name);
    end else if (we) begin
      compareValue({name, " data kept"}, lastRead, wbDatO);
    end else begin
      compareValue(name, exp, wbDatO);
    end
    if (!we) begin
      lastRead = exp;
    end
    @(posedge eboxClk);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
    @(negedge eboxClk);
    if (wbAck !== 1'b0) begin
      errors++;
      $display("%s: wbAck stayed high for more than one cycle", name);
    end
  endtask

  initial begin
    repeat (numVectors * 10 + 200) @(posedge eboxClk);
    $display("Timeout: tests did not finish within %0d cycles", numVectors * 10 + 200);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    cramT                   c;
    int                     f;
    int                     k;
    logic [fmDepthLog2-1:0] adr;
    errors = 0;
    checks = 0;
    lfsrState = 32'h5650;
    idleWord = '0;
    idleWord.adb = adbBr;
    idleWord.mqSel = mqHold;
    rstN = 1'b0;
    cram = idleWord;
    fmAdr = '0;
    curAdr = '0;
    cacheData = '0;
    shiftData = '0;
    vmaPc = randWord();
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = diagAr;
    shAr = '0;
    shArx = '0;
    shBr = '0;
    shBrx = '0;
    shMq = '0;
    lastRead = '0;
    repeat (5) @(posedge eboxClk);
    rstN <= 1'b1;

    // Reset state
    @(negedge eboxClk);
    checks++;
    if (wbAck !== 1'b0) begin
      errors++;
      $display("wbAck is high after reset with no request");
    end
    diagAccess(diagAr, 1'b0, "reset ar");
    diagAccess(diagBr, 1'b0, "reset br");
    diagAccess(diagMq, 1'b0, "reset mq");
    diagAccess(diagArx, 1'b0, "reset arx");
    diagAccess(diagBrx, 1'b0, "reset brx");

    // Every adder function on BR/BRX, one A source per pass
    for (f = 0; f < 8; f++) begin
      for (k = 0; k < 4; k++) begin
        loadArArx(randWord(), randWord(), 1'b0);
        loadArArx(randWord(), randWord(), 1'b1);
        c = idleWord;
        c.adFunc = adFuncT'(f);
        c.ada = adaSelT'(k);
        c.carryIn = (k == 0) ? 1'b1 : 1'(randBits(1));
        evalAd(c, $sformatf("adder func %0d pass %0d", f, k));
      end
    end

    // Half loads of AR and every ARX source, shifted B operands and gated A
    c = idleWord;
    c.mqmEn = 1'b1;
    c.mqmSel = mqmShift;
    c.mqSel = mqLoad;
    applyMicroword(c, '0, randWord(), curAdr);
    loadArArx(randWord(), randWord(), 1'b1);
    for (k = 0; k < 8; k++) begin
      c = idleWord;
      c.adFunc = adFuncT'(randBits(3));
      c.adb = adbSelT'(1 + k % 3);
      c.adaEn = k[1];
      c.arlSel = arSelT'(k);
      c.arrSel = arSelT'(7 - k);
      c.arxSel = arSelT'(k);
      c.arlLoad = k[0];
      c.arrLoad = !k[0];
      c.arxLoad = 1'b1;
      applyMicroword(c, randWord(), randWord(), curAdr);
      diagAccess(diagAr, 1'b0, $sformatf("ar half load %0d", k));
      diagAccess(diagArx, 1'b0, $sformatf("arx source %0d", k));
    end

    // MQ functions over all mixer sources, mixer on and off
    for (k = 0; k < 32; k++) begin
      c = idleWord;
      c.mqSel = mqSelT'(k[1:0]);
      c.mqmSel = mqmSelT'(k[3:2]);
      c.mqmEn = !k[4];
      c.adFunc = adFuncT'(randBits(1));
      c.carryIn = 1'(randBits(1));
      applyMicroword(c, randWord(), randWord(), curAdr);
      diagAccess(diagMq, 1'b0, $sformatf("mq case %0d", k));
    end

    // Left then right halfword write merge into one FM word
    for (k = 0; k < 4; k++) begin
      adr = fmDepthLog2'(randBits(fmDepthLog2));
      loadArArx(randWord(), randWord(), 1'b0);
      c = idleWord;
      c.fmWriteL = 1'b1;
      c.arlSel = arCache;
      c.arrSel = arCache;
      c.arlLoad = 1'b1;
      c.arrLoad = 1'b1;
      applyMicroword(c, randWord(), '0, adr);
      c = idleWord;
      c.fmWriteR = 1'b1;
      applyMicroword(c, '0, '0, adr);
      diagAccess(diagFm, 1'b0, $sformatf("fm merge %0d", k));
      c = idleWord;
      c.adb = adbFm;
      c.adFunc = adPassB;
      evalAd(c, $sformatf("fm through adb %0d", k));
    end

    // Wishbone selects, then a write that must change nothing
    for (k = 0; k < 8; k++) begin
      diagAccess(diagSelT'(k), 1'b0, $sformatf("wishbone sel %0d", k));
    end
    diagAccess(diagBr, 1'b1, "wishbone write");
    for (k = 0; k < 8; k++) begin
      diagAccess(diagSelT'(k), 1'b0, $sformatf("after write sel %0d", k));
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: hw/edp.sv
`timescale 1ns/1ps

module edp #(
  parameter int fmDepthLog2 = $bits(edpPkg::fmAdrT)
) (
  input  logic                   eboxClk,
  input  logic                   rstN,
  input  edpPkg::cramT           cram,
  input  logic [fmDepthLog2-1:0] fmAdr,
  input  edpPkg::wordT           cacheData,
  input  edpPkg::wordT           shiftData,
  input  edpPkg::wordT           vmaPc,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  edpPkg::diagSelT        wbAdr,
  output edpPkg::wordT           wbDatO,
  output logic                   wbAck,
  output edpPkg::adWordT         ad,
  output edpPkg::wordT           adx,
  output logic                   adCarryOut,
  output logic                   adOverflow
);
  import edpPkg::*;

  wordT ar;
  wordT arx;
  wordT br;
  wordT brx;
  wordT mq;
  wordT fm;

  edpArRegs arRegs (
    .eboxClk, .rstN, .cram, .cacheData, .shiftData,
    .ad, .adx, .mq,
    .ar, .arx, .br, .brx
  );

  edpMq mqUnit (
    .eboxClk, .rstN, .cram, .ad, .adx, .shiftData, .adCarryOut,
    .mq
  );

  edpAdder adder (
    .cram, .ar, .arx, .br, .brx, .mq, .fm, .vmaPc,
    .ad, .adx, .adCarryOut, .adOverflow
  );

  // AR is the fast memory write data
  edpFastMem #(
    .fmDepthLog2(fmDepthLog2)
  ) fastMem (
    .eboxClk, .cram, .fmAdr, .ar,
    .fm
  );

  edpDiagPort diagPort (
    .eboxClk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr,
    .ar, .br, .mq, .fm, .brx, .arx, .adx, .ad,
    .wbDatO, .wbAck
  );

endmodule

// File: hw/edpDiagPort.sv
`timescale 1ns/1ps

module edpDiagPort (
  input  logic            eboxClk,
  input  logic            rstN,
  input  logic            wbCyc,
  input  logic            wbStb,
  input  logic            wbWe,
  input  edpPkg::diagSelT wbAdr,
  input  edpPkg::wordT    ar,
  input  edpPkg::wordT    br,
  input  edpPkg::wordT    mq,
  input  edpPkg::wordT    fm,
  input  edpPkg::wordT    brx,
  input  edpPkg::wordT    arx,
  input  edpPkg::wordT    adx,
  input  edpPkg::adWordT  ad,
  output edpPkg::wordT    wbDatO,
  output logic            wbAck
);
  import edpPkg::*;

  typedef enum logic {
    diagIdle,
    diagAck
  } diagStateT;

  diagStateT state;
  wordT      selWord;

  always_comb begin
    case (wbAdr)
      diagAr:  selWord = ar;
      diagBr:  selWord = br;
      diagMq:  selWord = mq;
      diagFm:  selWord = fm;
      diagBrx: selWord = brx;
      diagArx: selWord = arx;
      diagAdx: selWord = adx;
      diagAd:  selWord = ad[0:35];
    endcase
  end

  // Ack state always drops back to idle, the held request is not seen twice
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      state <= diagIdle;
    end else begin
      case (state)
        diagIdle: if (wbCyc && wbStb) state <= diagAck;
        diagAck:  state <= diagIdle;
      endcase
    end
  end

  // Writes are acked but leave the read data alone
  always_ff @(posedge eboxClk) begin
    if (state == diagIdle && wbCyc && wbStb && !wbWe) begin
      wbDatO <= selWord;
    end
  end

  assign wbAck = (state == diagAck);

endmodule

// File: hw/edpFastMem.sv
`timescale 1ns/1ps

module edpFastMem #(
  parameter int fmDepthLog2 = $bits(edpPkg::fmAdrT)
) (
  input  logic                   eboxClk,
  input  edpPkg::cramT           cram,
  input  logic [fmDepthLog2-1:0] fmAdr,
  input  edpPkg::wordT           ar,
  output edpPkg::wordT           fm
);
  import edpPkg::*;

  wordT mem [2**fmDepthLog2];

  // Halfword writes of AR
  always_ff @(posedge eboxClk) begin
    if (cram.fmWriteL) begin
      mem[fmAdr][0:17] <= ar[0:17];
    end
    if (cram.fmWriteR) begin
      mem[fmAdr][18:35] <= ar[18:35];
    end
  end

  // Read is asynchronous
  assign fm = mem[fmAdr];

endmodule

// File: hw/edpAdder.sv
`timescale 1ns/1ps

module edpAdder (
  input  edpPkg::cramT   cram,
  input  edpPkg::wordT   ar,
  input  edpPkg::wordT   arx,
  input  edpPkg::wordT   br,
  input  edpPkg::wordT   brx,
  input  edpPkg::wordT   mq,
  input  edpPkg::wordT   fm,
  input  edpPkg::wordT   vmaPc,
  output edpPkg::adWordT ad,
  output edpPkg::wordT   adx,
  output logic           adCarryOut,
  output logic           adOverflow
);
  import edpPkg::*;

  wordT        ada;
  wordT        adxa;
  adWordT      adb;
  wordT        adxb;
  logic [38:0] adFull;
  logic [38:0] adxFull;

  // Shared function unit, carry out lands in bit 38
  function automatic logic [38:0] aluOp(
    input adFuncT      func,
    input logic [37:0] a,
    input logic [37:0] b,
    input logic        cin
  );
    logic [38:0] res;
    case (func)
      adAdd:   res = {1'b0, a} + {1'b0, b} + {38'd0, cin};
      // A plus ones complement of B, carry in makes it exact
      adSub:   res = {1'b0, a} + {1'b0, ~b} + {38'd0, cin};
      adAnd:   res = {1'b0, a & b};
      adOr:    res = {1'b0, a | b};
      adXor:   res = {1'b0, a ^ b};
      adPassA: res = {1'b0, a};
      adPassB: res = {1'b0, b};
      adOnes:  res = {1'b0, {38{1'b1}}};
    endcase
    return res;
  endfunction

  // A operands, adaEn high forces zero
  always_comb begin
    if (cram.adaEn) begin
      ada = '0;
    end else begin
      case (cram.ada)
        adaAr:    ada = ar;
        adaArx:   ada = arx;
        adaMq:    ada = mq;
        adaVmaPc: ada = vmaPc;
      endcase
    end
    adxa = cram.adaEn ? '0 : arx;
  end

  // B operands, BR/BRX and AR/ARX shift as double words
  always_comb begin
    case (cram.adb)
      adbFm: begin
        adb  = {{2{fm[0]}}, fm};
        adxb = '0;
      end
      adbBrShl: begin
        adb  = {{2{br[0]}}, br[1:35], brx[0]};
        adxb = {brx[1:35], 1'b0};
      end
      adbBr: begin
        adb  = {{2{br[0]}}, br};
        adxb = brx;
      end
      adbArShl2: begin
        adb  = {ar, arx[0:1]};
        adxb = {arx[2:35], 2'b00};
      end
    endcase
  end

  always_comb begin
    adFull  = aluOp(cram.adFunc, {{2{ada[0]}}, ada}, adb, cram.carryIn);
    adxFull = aluOp(cram.adFunc, {2'b00, adxa}, {2'b00, adxb}, cram.carryIn);
  end

  assign ad         = adFull[37:0];
  assign adCarryOut = adFull[38];
  assign adx        = adxFull[35:0];

  // Overflow when the extension bit disagrees with the sign
  assign adOverflow = (cram.adFunc == adAdd || cram.adFunc == adSub) ?
                      (ad[-1] ^ ad[0]) : 1'b0;

endmodule

// File: hw/edpMq.sv
`timescale 1ns/1ps

module edpMq (
  input  logic           eboxClk,
  input  logic           rstN,
  input  edpPkg::cramT   cram,
  input  edpPkg::adWordT ad,
  input  edpPkg::wordT   adx,
  input  edpPkg::wordT   shiftData,
  input  logic           adCarryOut,
  output edpPkg::wordT   mq
);
  import edpPkg::*;

  wordT mqm;

  // MQ mixer, forced to zero when disabled
  always_comb begin
    if (!cram.mqmEn) begin
      mqm = '0;
    end else begin
      case (cram.mqmSel)
        // Two-place right shift, low ADX bits move in on top
        mqmMqShr: mqm = {adx[34:35], mq[0:33]};
        mqmShift: mqm = shiftData;
        mqmAd:    mqm = ad[0:35];
        mqmOnes:  mqm = '1;
      endcase
    end
  end

  // Universal shift register
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      mq <= '0;
    end else begin
      case (cram.mqSel)
        mqLoad: mq <= mqm;
        // Adder carry enters at the low end
        mqShl:  mq <= {mqm[1:35], adCarryOut};
        // Vacated bit 0 refilled from MQM bit 1
        mqShr:  mq <= {mqm[1], mqm[0:34]};
        mqHold: mq <= mq;
      endcase
    end
  end

endmodule

// File: hw/edpArRegs.sv
`timescale 1ns/1ps

module edpArRegs (
  input  logic           eboxClk,
  input  logic           rstN,
  input  edpPkg::cramT   cram,
  input  edpPkg::wordT   cacheData,
  input  edpPkg::wordT   shiftData,
  input  edpPkg::adWordT ad,
  input  edpPkg::wordT   adx,
  input  edpPkg::wordT   mq,
  output edpPkg::wordT   ar,
  output edpPkg::wordT   arx,
  output edpPkg::wordT   br,
  output edpPkg::wordT   brx
);
  import edpPkg::*;

  wordT arlFull;
  wordT arrFull;
  halfT arlIn;
  halfT arrIn;
  wordT arxIn;

  // Full-word AR source, each half takes its own slice
  function automatic wordT arSource(input arSelT sel);
    wordT src;
    case (sel)
      arZero:   src = '0;
      arCache:  src = cacheData;
      arAd:     src = ad[0:35];
      arMq:     src = mq;
      arShift:  src = shiftData;
      // AD times two, ADX bit 0 fills the low end
      arAdShl:  src = {ad[1:35], adx[0]};
      arAdx:    src = adx;
      // AD divided by four, extension bits enter at the top
      arAdShr2: src = ad[-2:33];
    endcase
    return src;
  endfunction

  always_comb begin
    arlFull = arSource(cram.arlSel);
    arrFull = arSource(cram.arrSel);
    arlIn   = arlFull[0:17];
    arrIn   = arrFull[18:35];
  end

  // ARX is the low word of the AD/ADX pair, so its shifts use ADX and MQ
  always_comb begin
    case (cram.arxSel)
      arZero:   arxIn = '0;
      arCache:  arxIn = cacheData;
      arAd:     arxIn = ad[0:35];
      arMq:     arxIn = mq;
      arShift:  arxIn = shiftData;
      arAdShl:  arxIn = {adx[1:35], mq[0]};
      arAdx:    arxIn = adx;
      arAdShr2: arxIn = {ad[34:35], adx[0:33]};
    endcase
  end

  // AR halves load independently
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      ar <= '0;
    end else begin
      if (cram.arlLoad) begin
        ar[0:17] <= arlIn;
      end
      if (cram.arrLoad) begin
        ar[18:35] <= arrIn;
      end
    end
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      arx <= '0;
    end else if (cram.arxLoad) begin
      arx <= arxIn;
    end
  end

  // BR and BRX take the old AR and ARX values
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      br  <= '0;
      brx <= '0;
    end else begin
      if (cram.brLoad) begin
        br <= ar;
      end
      if (cram.brxLoad) begin
        brx <= arx;
      end
    end
  end

endmodule

// File: hw/edpPkg.sv
package edpPkg;

  // Data words are numbered MSB first, bit 0 is the sign
  typedef logic [0:35] wordT;
  typedef logic [0:17] halfT;
  // Two sign-extension bits ahead of the 36 data bits
  typedef logic [-2:35] adWordT;
  typedef logic [6:0] fmAdrT;

  // Adder function codes
  typedef logic [2:0] adFuncT;
  localparam adFuncT adAdd   = 3'd0;
  localparam adFuncT adSub   = 3'd1;
  localparam adFuncT adAnd   = 3'd2;
  localparam adFuncT adOr    = 3'd3;
  localparam adFuncT adXor   = 3'd4;
  localparam adFuncT adPassA = 3'd5;
  localparam adFuncT adPassB = 3'd6;
  localparam adFuncT adOnes  = 3'd7;

  // AR and ARX source select
  typedef logic [2:0] arSelT;
  localparam arSelT arZero   = 3'd0;
  localparam arSelT arCache  = 3'd1;
  localparam arSelT arAd     = 3'd2;
  localparam arSelT arMq     = 3'd3;
  localparam arSelT arShift  = 3'd4;
  localparam arSelT arAdShl  = 3'd5;
  localparam arSelT arAdx    = 3'd6;
  localparam arSelT arAdShr2 = 3'd7;

  // Adder A operand
  typedef logic [1:0] adaSelT;
  localparam adaSelT adaAr    = 2'd0;
  localparam adaSelT adaArx   = 2'd1;
  localparam adaSelT adaMq    = 2'd2;
  localparam adaSelT adaVmaPc = 2'd3;

  // Adder B operand
  typedef logic [1:0] adbSelT;
  localparam adbSelT adbFm     = 2'd0;
  localparam adbSelT adbBrShl  = 2'd1;
  localparam adbSelT adbBr     = 2'd2;
  localparam adbSelT adbArShl2 = 2'd3;

  // MQ shift register function
  typedef logic [1:0] mqSelT;
  localparam mqSelT mqLoad = 2'd0;
  localparam mqSelT mqShl  = 2'd1;
  localparam mqSelT mqShr  = 2'd2;
  localparam mqSelT mqHold = 2'd3;

  // MQ mixer source
  typedef logic [1:0] mqmSelT;
  localparam mqmSelT mqmMqShr = 2'd0;
  localparam mqmSelT mqmShift = 2'd1;
  localparam mqmSelT mqmAd    = 2'd2;
  localparam mqmSelT mqmOnes  = 2'd3;

  // Diagnostic register select
  typedef logic [2:0] diagSelT;
  localparam diagSelT diagAr  = 3'd0;
  localparam diagSelT diagBr  = 3'd1;
  localparam diagSelT diagMq  = 3'd2;
  localparam diagSelT diagFm  = 3'd3;
  localparam diagSelT diagBrx = 3'd4;
  localparam diagSelT diagArx = 3'd5;
  localparam diagSelT diagAdx = 3'd6;
  localparam diagSelT diagAd  = 3'd7;

  typedef struct packed {
    adFuncT adFunc;
    adaSelT ada;
    logic   adaEn;
    adbSelT adb;
    arSelT  arlSel;
    arSelT  arrSel;
    logic   arlLoad;
    logic   arrLoad;
    arSelT  arxSel;
    logic   arxLoad;
    logic   brLoad;
    logic   brxLoad;
    mqSelT  mqSel;
    mqmSelT mqmSel;
    logic   mqmEn;
    logic   fmWriteL;
    logic   fmWriteR;
    logic   carryIn;
  } cramT;

endpackage
